// File: rv_pkg.sv
// execute pipe shared types
`default_nettype none

package rv_pkg;

  // data ram geometry
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW = 6;

  // data and address word
  typedef logic [63:0] reg_t;

  // register file index
  typedef logic [4:0] rd_addr_t;

  // word index into the data ram
  typedef logic [DMEM_AW-1:0] dmem_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD      = 4'd0,
    ALU_SUB      = 4'd1,
    ALU_SLL      = 4'd2,
    ALU_SLT      = 4'd3,
    ALU_SLTU     = 4'd4,
    ALU_XOR      = 4'd5,
    ALU_SRL      = 4'd6,
    ALU_SRA      = 4'd7,
    ALU_OR       = 4'd8,
    ALU_AND      = 4'd9,
    ALU_PASS_OP2 = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    BJ_NONE = 4'd0,
    BJ_BEQ  = 4'd1,
    BJ_BNE  = 4'd2,
    BJ_BLT  = 4'd3,
    BJ_BGE  = 4'd4,
    BJ_BLTU = 4'd5,
    BJ_BGEU = 4'd6,
    BJ_JAL  = 4'd7,
    BJ_JALR = 4'd8
  } bj_op_e;

  // lbu/lhu/lwu zero extend, the rest sign extend
  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_LB   = 3'd1,
    LD_LH   = 3'd2,
    LD_LW   = 3'd3,
    LD_LD   = 3'd4,
    LD_LBU  = 3'd5,
    LD_LHU  = 3'd6,
    LD_LWU  = 3'd7
  } load_op_e;

  typedef enum logic [2:0] {
    ST_NONE = 3'd0,
    ST_SB   = 3'd1,
    ST_SH   = 3'd2,
    ST_SW   = 3'd3,
    ST_SD   = 3'd4
  } save_op_e;

endpackage

`default_nettype wire

// File: ex_stage_alu.sv
// execute stage alu
`timescale 1ns/10ps
`default_nettype none

module ex_stage_alu (
  input  wire rv_pkg::reg_t    op1,
  input  wire rv_pkg::reg_t    op2,
  input  wire rv_pkg::alu_op_e alu_op,
  input  wire                  is_word_opt,
  output rv_pkg::reg_t         alu_result,
  output logic                 eq,
  output logic                 lt,
  output logic                 ltu
);

  logic [5:0]   shamt64;
  logic [4:0]   shamt32;
  logic [31:0]  op1_w;
  logic [31:0]  op2_w;
  rv_pkg::reg_t res64;
  logic [31:0]  res32;

  assign shamt64 = op2[5:0];
  assign shamt32 = op2[4:0];
  assign op1_w = op1[31:0];
  assign op2_w = op2[31:0];

  // flags always see the full operands
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:      res64 = op1 + op2;
      rv_pkg::ALU_SUB:      res64 = op1 - op2;
      rv_pkg::ALU_SLL:      res64 = op1 << shamt64;
      rv_pkg::ALU_SLT:      res64 = {63'd0, lt};
      rv_pkg::ALU_SLTU:     res64 = {63'd0, ltu};
      rv_pkg::ALU_XOR:      res64 = op1 ^ op2;
      rv_pkg::ALU_SRL:      res64 = op1 >> shamt64;
      rv_pkg::ALU_SRA:      res64 = $signed(op1) >>> shamt64;
      rv_pkg::ALU_OR:       res64 = op1 | op2;
      rv_pkg::ALU_AND:      res64 = op1 & op2;
      rv_pkg::ALU_PASS_OP2: res64 = op2;
      default:              res64 = '0;
    endcase
  end

  // word variants on the low halves
  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:      res32 = op1_w + op2_w;
      rv_pkg::ALU_SUB:      res32 = op1_w - op2_w;
      rv_pkg::ALU_SLL:      res32 = op1_w << shamt32;
      rv_pkg::ALU_SLT:      res32 = {31'd0, $signed(op1_w) < $signed(op2_w)};
      rv_pkg::ALU_SLTU:     res32 = {31'd0, op1_w < op2_w};
      rv_pkg::ALU_XOR:      res32 = op1_w ^ op2_w;
      rv_pkg::ALU_SRL:      res32 = op1_w >> shamt32;
      rv_pkg::ALU_SRA:      res32 = $signed(op1_w) >>> shamt32;
      rv_pkg::ALU_OR:       res32 = op1_w | op2_w;
      rv_pkg::ALU_AND:      res32 = op1_w & op2_w;
      rv_pkg::ALU_PASS_OP2: res32 = op2_w;
      default:              res32 = '0;
    endcase
  end

  assign alu_result = is_word_opt ? {{32{res32[31]}}, res32} : res64;

endmodule

`default_nettype wire

// File: ex_stage_bj.sv
// branch and jump resolution
`timescale 1ns/10ps
`default_nettype none

module ex_stage_bj (
  input  wire rv_pkg::bj_op_e bj_op,
  input  wire                 valid,
  input  wire                 eq,
  input  wire                 lt,
  input  wire                 ltu,
  input  wire rv_pkg::reg_t   now_pc,
  input  wire rv_pkg::reg_t   exe_op1,
  input  wire rv_pkg::reg_t   jmp_imm,
  output logic                bj_ena,
  output rv_pkg::reg_t        new_pc
);

  logic         taken;
  rv_pkg::reg_t jalr_sum;

  always_comb begin
    case (bj_op)
      rv_pkg::BJ_BEQ:  taken = eq;
      rv_pkg::BJ_BNE:  taken = !eq;
      rv_pkg::BJ_BLT:  taken = lt;
      rv_pkg::BJ_BGE:  taken = !lt;
      rv_pkg::BJ_BLTU: taken = ltu;
      rv_pkg::BJ_BGEU: taken = !ltu;
      rv_pkg::BJ_JAL:  taken = 1'b1;
      rv_pkg::BJ_JALR: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  assign bj_ena = valid && taken;

  // jalr target drops bit 0
  assign jalr_sum = exe_op1 + jmp_imm;
  assign new_pc = (bj_op == rv_pkg::BJ_JALR) ? {jalr_sum[63:1], 1'b0} : now_pc + jmp_imm;

endmodule

`default_nettype wire

// File: ex_stage.sv
// execute stage
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   id_ex_valid,
  output logic                  ex_allowin,
  input  wire                   mem_allowin,
  output logic                  ex_mem_valid,
  input  wire rv_pkg::reg_t     pc_in,
  input  wire rv_pkg::reg_t     op1_src,
  input  wire rv_pkg::reg_t     op2_src,
  input  wire rv_pkg::alu_op_e  alu_op,
  input  wire                   is_word_opt,
  input  wire rv_pkg::bj_op_e   bj_op,
  input  wire rv_pkg::reg_t     jmp_imm,
  input  wire rv_pkg::load_op_e load_op_in,
  input  wire rv_pkg::save_op_e save_op_in,
  input  wire rv_pkg::reg_t     mem_wr_src_in,
  input  wire                   rd_ena_in,
  input  wire rv_pkg::rd_addr_t rd_addr_in,
  output rv_pkg::reg_t          pc_out,
  output rv_pkg::load_op_e      load_op_out,
  output rv_pkg::save_op_e      save_op_out,
  output rv_pkg::reg_t          mem_wr_src_out,
  output logic                  rd_ena_out,
  output rv_pkg::rd_addr_t      rd_addr_out,
  output rv_pkg::reg_t          ex_data,
  output logic                  bj_ena,
  output rv_pkg::reg_t          new_pc
);

  logic         ex_valid;
  logic         ex_ready_go;
  logic         ex_accept;
  rv_pkg::reg_t alu_result;
  logic         alu_eq;
  logic         alu_lt;
  logic         alu_ltu;

  // single cycle stage
  assign ex_ready_go = 1'b1;
  assign ex_allowin = !ex_valid || (ex_ready_go && mem_allowin);
  assign ex_mem_valid = ex_valid && ex_ready_go;
  assign ex_accept = id_ex_valid && ex_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_ex_valid;
    end
  end

  ex_stage_alu ex_stage_alu_inst (
    .op1         (op1_src),
    .op2         (op2_src),
    .alu_op      (alu_op),
    .is_word_opt (is_word_opt),
    .alu_result  (alu_result),
    .eq          (alu_eq),
    .lt          (alu_lt),
    .ltu         (alu_ltu)
  );

  // redirect resolves in the same cycle as the inputs
  ex_stage_bj ex_stage_bj_inst (
    .bj_op   (bj_op),
    .valid   (id_ex_valid),
    .eq      (alu_eq),
    .lt      (alu_lt),
    .ltu     (alu_ltu),
    .now_pc  (pc_in),
    .exe_op1 (op1_src),
    .jmp_imm (jmp_imm),
    .bj_ena  (bj_ena),
    .new_pc  (new_pc)
  );

  always_ff @(posedge clk) begin
    if (ex_accept) begin
      pc_out         <= pc_in;
      load_op_out    <= load_op_in;
      save_op_out    <= save_op_in;
      mem_wr_src_out <= mem_wr_src_in;
      rd_ena_out     <= rd_ena_in;
      rd_addr_out    <= rd_addr_in;
      ex_data        <= alu_result;
    end
  end

endmodule

`default_nettype wire

// File: mem_stage.sv
// memory stage with data ram
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   ex_mem_valid,
  output logic                  mem_allowin,
  input  wire                   wb_allowin,
  output logic                  mem_wb_valid,
  input  wire rv_pkg::reg_t     pc_in,
  input  wire rv_pkg::reg_t     ex_data,
  input  wire rv_pkg::load_op_e load_op,
  input  wire rv_pkg::save_op_e save_op,
  input  wire rv_pkg::reg_t     mem_wr_src,
  input  wire                   rd_ena_in,
  input  wire rv_pkg::rd_addr_t rd_addr_in,
  output rv_pkg::reg_t          wb_pc,
  output logic                  wb_rd_ena,
  output rv_pkg::rd_addr_t      wb_rd_addr,
  output rv_pkg::reg_t          wb_data
);

  rv_pkg::reg_t       dmem [rv_pkg::DMEM_WORDS];
  logic               mem_valid;
  logic               mem_ready_go;
  logic               mem_accept;
  rv_pkg::dmem_addr_t word_idx;
  logic [2:0]         lane_off;
  logic [7:0]         st_mask;
  rv_pkg::reg_t       st_data;
  rv_pkg::reg_t       rd_lanes;
  rv_pkg::reg_t       load_data;

  assign mem_ready_go = 1'b1;
  assign mem_allowin = !mem_valid || (mem_ready_go && wb_allowin);
  assign mem_wb_valid = mem_valid && mem_ready_go;
  assign mem_accept = ex_mem_valid && mem_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_mem_valid;
    end
  end

  assign word_idx = ex_data[rv_pkg::DMEM_AW+2:3];
  assign lane_off = ex_data[2:0];

  // replicate store data so every lane position sees it
  always_comb begin
    case (save_op)
      rv_pkg::ST_SB: begin
        st_mask = 8'h01 << lane_off;
        st_data = {8{mem_wr_src[7:0]}};
      end
      rv_pkg::ST_SH: begin
        st_mask = 8'h03 << lane_off;
        st_data = {4{mem_wr_src[15:0]}};
      end
      rv_pkg::ST_SW: begin
        st_mask = 8'h0f << lane_off;
        st_data = {2{mem_wr_src[31:0]}};
      end
      rv_pkg::ST_SD: begin
        st_mask = 8'hff;
        st_data = mem_wr_src;
      end
      default: begin
        st_mask = 8'h00;
        st_data = mem_wr_src;
      end
    endcase
  end

  initial begin
    for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
      dmem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (mem_accept) begin
      for (int b = 0; b < 8; b++) begin
        if (st_mask[b]) begin
          dmem[word_idx][b*8 +: 8] <= st_data[b*8 +: 8];
        end
      end
    end
  end

  // addressed lane moved down to bit 0
  assign rd_lanes = dmem[word_idx] >> {lane_off, 3'b000};

  always_comb begin
    case (load_op)
      rv_pkg::LD_LB:  load_data = {{56{rd_lanes[7]}}, rd_lanes[7:0]};
      rv_pkg::LD_LH:  load_data = {{48{rd_lanes[15]}}, rd_lanes[15:0]};
      rv_pkg::LD_LW:  load_data = {{32{rd_lanes[31]}}, rd_lanes[31:0]};
      rv_pkg::LD_LD:  load_data = rd_lanes;
      rv_pkg::LD_LBU: load_data = {56'd0, rd_lanes[7:0]};
      rv_pkg::LD_LHU: load_data = {48'd0, rd_lanes[15:0]};
      rv_pkg::LD_LWU: load_data = {32'd0, rd_lanes[31:0]};
      default:        load_data = ex_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_accept) begin
      wb_pc      <= pc_in;
      wb_rd_ena  <= rd_ena_in;
      wb_rd_addr <= rd_addr_in;
      wb_data    <= load_data;
    end
  end

endmodule

`default_nettype wire

// File: exec_pipe_top.sv
// execute and memory pipe
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   id_ex_valid,
  output logic                  ex_allowin,
  input  wire rv_pkg::reg_t     pc_in,
  input  wire rv_pkg::reg_t     op1_src,
  input  wire rv_pkg::reg_t     op2_src,
  input  wire rv_pkg::alu_op_e  alu_op,
  input  wire                   is_word_opt,
  input  wire rv_pkg::bj_op_e   bj_op,
  input  wire rv_pkg::reg_t     jmp_imm,
  input  wire rv_pkg::load_op_e load_op_in,
  input  wire rv_pkg::save_op_e save_op_in,
  input  wire rv_pkg::reg_t     mem_wr_src_in,
  input  wire                   rd_ena_in,
  input  wire rv_pkg::rd_addr_t rd_addr_in,
  output logic                  bj_ena,
  output rv_pkg::reg_t          new_pc,
  input  wire                   wb_allowin,
  output logic                  mem_wb_valid,
  output rv_pkg::reg_t          wb_pc,
  output logic                  wb_rd_ena,
  output rv_pkg::rd_addr_t      wb_rd_addr,
  output rv_pkg::reg_t          wb_data
);

  logic             mem_allowin;
  logic             ex_mem_valid;
  rv_pkg::reg_t     ex_pc;
  rv_pkg::load_op_e ex_load_op;
  rv_pkg::save_op_e ex_save_op;
  rv_pkg::reg_t     ex_mem_wr_src;
  logic             ex_rd_ena;
  rv_pkg::rd_addr_t ex_rd_addr;
  rv_pkg::reg_t     ex_data;

  ex_stage ex_stage_inst (
    .clk            (clk),
    .rst            (rst),
    .id_ex_valid    (id_ex_valid),
    .ex_allowin     (ex_allowin),
    .mem_allowin    (mem_allowin),
    .ex_mem_valid   (ex_mem_valid),
    .pc_in          (pc_in),
    .op1_src        (op1_src),
    .op2_src        (op2_src),
    .alu_op         (alu_op),
    .is_word_opt    (is_word_opt),
    .bj_op          (bj_op),
    .jmp_imm        (jmp_imm),
    .load_op_in     (load_op_in),
    .save_op_in     (save_op_in),
    .mem_wr_src_in  (mem_wr_src_in),
    .rd_ena_in      (rd_ena_in),
    .rd_addr_in     (rd_addr_in),
    .pc_out         (ex_pc),
    .load_op_out    (ex_load_op),
    .save_op_out    (ex_save_op),
    .mem_wr_src_out (ex_mem_wr_src),
    .rd_ena_out     (ex_rd_ena),
    .rd_addr_out    (ex_rd_addr),
    .ex_data        (ex_data),
    .bj_ena         (bj_ena),
    .new_pc         (new_pc)
  );

  mem_stage mem_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .ex_mem_valid (ex_mem_valid),
    .mem_allowin  (mem_allowin),
    .wb_allowin   (wb_allowin),
    .mem_wb_valid (mem_wb_valid),
    .pc_in        (ex_pc),
    .ex_data      (ex_data),
    .load_op      (ex_load_op),
    .save_op      (ex_save_op),
    .mem_wr_src   (ex_mem_wr_src),
    .rd_ena_in    (ex_rd_ena),
    .rd_addr_in   (ex_rd_addr),
    .wb_pc        (wb_pc),
    .wb_rd_ena    (wb_rd_ena),
    .wb_rd_addr   (wb_rd_addr),
    .wb_data      (wb_data)
  );

endmodule

`default_nettype wire

// File: exec_pipe_asserts.sv
// handshake and redirect assertions
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_asserts (
  input wire clk,
  input wire rst,
  input wire in_valid,
  input wire out_valid,
  input wire out_allowin,
  input wire redirect
);

  // a stalled stage keeps its instruction
  hold_valid: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_allowin |=> out_valid)
    else $error("valid dropped while downstream stalled");

  reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("stage accepted during reset");

  redirect_valid: assert property (@(posedge clk) disable iff (rst)
    redirect |-> in_valid)
    else $error("redirect without a valid instruction");

endmodule

bind ex_stage exec_pipe_asserts ex_chk (
  .clk         (clk),
  .rst         (rst),
  .in_valid    (id_ex_valid),
  .out_valid   (ex_mem_valid),
  .out_allowin (mem_allowin),
  .redirect    (bj_ena)
);

bind mem_stage exec_pipe_asserts mem_chk (
  .clk         (clk),
  .rst         (rst),
  .in_valid    (ex_mem_valid),
  .out_valid   (mem_wb_valid),
  .out_allowin (wb_allowin),
  .redirect    (1'b0)
);

`default_nettype wire

// File: tb_exec_pipe.sv
// execute pipe testbench
`timescale 1ns/10ps
`default_nettype none

module tb_exec_pipe;

  localparam int NT = 50;
  localparam int RUNS = 2;

  logic clk;
  logic rst;
  logic id_ex_valid;
  logic ex_allowin;
  rv_pkg::reg_t pc_in;
  rv_pkg::reg_t op1_src;
  rv_pkg::reg_t op2_src;
  rv_pkg::alu_op_e alu_op;
  logic is_word_opt;
  rv_pkg::bj_op_e bj_op;
  rv_pkg::reg_t jmp_imm;
  rv_pkg::load_op_e load_op_in;
  rv_pkg::save_op_e save_op_in;
  rv_pkg::reg_t mem_wr_src_in;
  logic rd_ena_in;
  rv_pkg::rd_addr_t rd_addr_in;
  logic bj_ena;
  rv_pkg::reg_t new_pc;
  logic wb_allowin;
  logic mem_wb_valid;
  rv_pkg::reg_t wb_pc;
  logic wb_rd_ena;
  rv_pkg::rd_addr_t wb_rd_addr;
  rv_pkg::reg_t wb_data;

  // stimulus table
  rv_pkg::alu_op_e  t_alu [NT];
  logic             t_word [NT];
  rv_pkg::reg_t     t_op1 [NT];
  rv_pkg::reg_t     t_op2 [NT];
  rv_pkg::bj_op_e   t_bj [NT];
  rv_pkg::reg_t     t_imm [NT];
  rv_pkg::reg_t     t_pc [NT];
  rv_pkg::load_op_e t_ld [NT];
  rv_pkg::save_op_e t_st [NT];
  rv_pkg::reg_t     t_wsrc [NT];
  rv_pkg::reg_t     t_data [NT];
  logic             t_bjena [NT];
  rv_pkg::reg_t     t_npc [NT];

  // redirect mismatches seen while the entry was driven
  logic             drive_bad [NT];

  int n_tab = 0;
  int errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  int cycle = 0;
  int q_idx[$];
  int q_cyc[$];
  logic check_lat = 1'b1;
  logic bp_on = 1'b0;
  logic [31:0] lfsr = 32'ha183;
  logic bad;
  int idx;
  int lat;

  exec_pipe_top exec_pipe_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (RUNS * NT * 20 + 100) @(posedge clk);
    $display("timeout: write-back stopped before all instructions came out");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic add_test(input rv_pkg::alu_op_e a, input logic w, input rv_pkg::reg_t o1,
                          input rv_pkg::reg_t o2, input rv_pkg::bj_op_e b,
                          input rv_pkg::reg_t imm, input rv_pkg::reg_t pc,
                          input rv_pkg::load_op_e ld, input rv_pkg::save_op_e st,
                          input rv_pkg::reg_t ws, input rv_pkg::reg_t d,
                          input logic be, input rv_pkg::reg_t np);
    t_alu[n_tab] = a;
    t_word[n_tab] = w;
    t_op1[n_tab] = o1;
    t_op2[n_tab] = o2;
    t_bj[n_tab] = b;
    t_imm[n_tab] = imm;
    t_pc[n_tab] = pc;
    t_ld[n_tab] = ld;
    t_st[n_tab] = st;
    t_wsrc[n_tab] = ws;
    t_data[n_tab] = d;
    t_bjena[n_tab] = be;
    t_npc[n_tab] = np;
    n_tab++;
  endtask

  // plain alu entry, no branch and no memory access
  task automatic add_alu(input rv_pkg::alu_op_e a, input logic w, input rv_pkg::reg_t o1,
                         input rv_pkg::reg_t o2, input rv_pkg::reg_t d);
    add_test(a, w, o1, o2, rv_pkg::BJ_NONE, 0, 64'h1000, rv_pkg::LD_NONE, rv_pkg::ST_NONE,
             0, d, 1'b0, 64'h1000);
  endtask

  task automatic add_mem(input rv_pkg::reg_t addr, input rv_pkg::load_op_e ld,
                         input rv_pkg::save_op_e st, input rv_pkg::reg_t ws,
                         input rv_pkg::reg_t d);
    add_test(rv_pkg::ALU_ADD, 1'b0, addr, 0, rv_pkg::BJ_NONE, 0, 64'h1000, ld, st, ws, d,
             1'b0, 64'h1000);
  endtask

  task automatic add_br(input rv_pkg::bj_op_e b, input rv_pkg::reg_t o1,
                        input rv_pkg::reg_t o2, input rv_pkg::reg_t pc,
                        input rv_pkg::reg_t imm, input logic be, input rv_pkg::reg_t np);
    add_test(rv_pkg::ALU_PASS_OP2, 1'b0, o1, o2, b, imm, pc, rv_pkg::LD_NONE,
             rv_pkg::ST_NONE, 0, o2, be, np);
  endtask

  task automatic build_table;
    add_alu(rv_pkg::ALU_ADD, 1'b0, 64'd5, 64'd7, 64'd12);
    add_alu(rv_pkg::ALU_SUB, 1'b0, 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe);
    add_alu(rv_pkg::ALU_SLL, 1'b0, 64'd1, 64'h43, 64'd8);
    add_alu(rv_pkg::ALU_SLT, 1'b0, '1, 64'd1, 64'd1);
    add_alu(rv_pkg::ALU_SLTU, 1'b0, '1, 64'd1, 64'd0);
    add_alu(rv_pkg::ALU_XOR, 1'b0, 64'hf0f0, 64'hff00, 64'h0ff0);
    add_alu(rv_pkg::ALU_SRL, 1'b0, 64'h8000_0000_0000_0000, 64'd4, 64'h0800_0000_0000_0000);
    add_alu(rv_pkg::ALU_SRA, 1'b0, 64'h8000_0000_0000_0000, 64'd4, 64'hf800_0000_0000_0000);
    add_alu(rv_pkg::ALU_OR, 1'b0, 64'h0f00, 64'h00f0, 64'h0ff0);
    add_alu(rv_pkg::ALU_AND, 1'b0, 64'hff00, 64'h0ff0, 64'h0f00);
    add_alu(rv_pkg::ALU_PASS_OP2, 1'b0, 64'd9, 64'h1234, 64'h1234);
    add_alu(rv_pkg::ALU_ADD, 1'b1, 64'h1234_5678_7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
    add_alu(rv_pkg::ALU_SUB, 1'b1, 64'd0, 64'd1, 64'hffff_ffff_ffff_ffff);
    add_alu(rv_pkg::ALU_SLL, 1'b1, 64'd1, 64'h3f, 64'hffff_ffff_8000_0000);
    add_alu(rv_pkg::ALU_SRL, 1'b1, 64'hffff_ffff_8000_0000, 64'd4, 64'h0000_0000_0800_0000);
    add_alu(rv_pkg::ALU_SRA, 1'b1, 64'hffff_ffff_8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
    add_alu(rv_pkg::ALU_SLT, 1'b1, 64'h0000_0000_8000_0000, 64'd1, 64'd1);
    add_alu(rv_pkg::ALU_SLTU, 1'b1, 64'h0000_0001_0000_0000, 64'd1, 64'd1);
    add_alu(rv_pkg::ALU_XOR, 1'b1, 64'h1111_1111_0f0f_0f0f, 64'h2222_2222_f0f0_f0f0, '1);
    add_alu(rv_pkg::ALU_OR, 1'b1, 64'hffff_0000_0000_00f0, 64'h0f, 64'hff);
    add_alu(rv_pkg::ALU_AND, 1'b1, 64'h0000_0001_8000_0001, 64'hffff_ffff_8000_0000,
            64'hffff_ffff_8000_0000);
    add_alu(rv_pkg::ALU_PASS_OP2, 1'b1, 64'd9, 64'h1234_5678_9abc_def0,
            64'hffff_ffff_9abc_def0);
    // branches, result is op2
    add_br(rv_pkg::BJ_BEQ, 64'd5, 64'd5, 64'h2000, 64'h10, 1'b1, 64'h2010);
    add_br(rv_pkg::BJ_BNE, 64'd5, 64'd5, 64'h2000, 64'h10, 1'b0, 64'h2010);
    add_br(rv_pkg::BJ_BLT, '1, 64'd1, 64'h2000, 64'h20, 1'b1, 64'h2020);
    add_br(rv_pkg::BJ_BLTU, '1, 64'd1, 64'h2000, 64'h20, 1'b0, 64'h2020);
    add_br(rv_pkg::BJ_BGE, 64'd1, '1, 64'h2000, 64'h40, 1'b1, 64'h2040);
    add_br(rv_pkg::BJ_BGEU, 64'd1, '1, 64'h2000, 64'h40, 1'b0, 64'h2040);
    add_br(rv_pkg::BJ_BEQ, 64'd5, 64'd6, 64'h2000, 64'h10, 1'b0, 64'h2010);
    add_br(rv_pkg::BJ_BNE, 64'd5, 64'd6, 64'h2000, 64'h10, 1'b1, 64'h2010);
    add_br(rv_pkg::BJ_BLT, 64'd1, '1, 64'h2000, 64'h20, 1'b0, 64'h2020);
    add_br(rv_pkg::BJ_BLTU, 64'd1, '1, 64'h2000, 64'h20, 1'b1, 64'h2020);
    add_br(rv_pkg::BJ_BGE, '1, 64'd1, 64'h2000, 64'h40, 1'b0, 64'h2040);
    add_br(rv_pkg::BJ_BGEU, '1, 64'd1, 64'h2000, 64'h40, 1'b1, 64'h2040);
    add_br(rv_pkg::BJ_JAL, 64'd0, 64'h3004, 64'h3000, 64'h100, 1'b1, 64'h3100);
    add_br(rv_pkg::BJ_JALR, 64'h4001, 64'h3008, 64'h3004, 64'h10, 1'b1, 64'h4010);
    // stores report their address, word 2 and word 3
    add_mem(64'h10, rv_pkg::LD_NONE, rv_pkg::ST_SD, 64'h1122_3344_5566_7788, 64'h10);
    add_mem(64'h11, rv_pkg::LD_NONE, rv_pkg::ST_SB, 64'hab, 64'h11);
    add_mem(64'h14, rv_pkg::LD_NONE, rv_pkg::ST_SH, 64'hbeef, 64'h14);
    add_mem(64'h18, rv_pkg::LD_NONE, rv_pkg::ST_SW, 64'h8765_4321, 64'h18);
    add_mem(64'h10, rv_pkg::LD_LD, rv_pkg::ST_NONE, 0, 64'h1122_beef_5566_ab88);
    add_mem(64'h11, rv_pkg::LD_LB, rv_pkg::ST_NONE, 0, 64'hffff_ffff_ffff_ffab);
    add_mem(64'h11, rv_pkg::LD_LBU, rv_pkg::ST_NONE, 0, 64'hab);
    add_mem(64'h14, rv_pkg::LD_LH, rv_pkg::ST_NONE, 0, 64'hffff_ffff_ffff_beef);
    add_mem(64'h14, rv_pkg::LD_LHU, rv_pkg::ST_NONE, 0, 64'hbeef);
    add_mem(64'h10, rv_pkg::LD_LW, rv_pkg::ST_NONE, 0, 64'h5566_ab88);
    add_mem(64'h18, rv_pkg::LD_LW, rv_pkg::ST_NONE, 0, 64'hffff_ffff_8765_4321);
    add_mem(64'h18, rv_pkg::LD_LWU, rv_pkg::ST_NONE, 0, 64'h8765_4321);
    add_mem(64'h17, rv_pkg::LD_LB, rv_pkg::ST_NONE, 0, 64'h11);
    add_mem(64'h16, rv_pkg::LD_LH, rv_pkg::ST_NONE, 0, 64'h1122);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(negedge clk) begin
    if (bp_on) begin
      lfsr = lfsr_step(lfsr);
      wb_allowin = lfsr[0];
    end
  end

  // scoreboard on write-back
  always @(posedge clk) begin
    if (!rst && mem_wb_valid && wb_allowin) begin
      if (q_idx.size() == 0) begin
        $display("%0t: write-back with no instruction outstanding", $time);
        errors++;
      end else begin
        idx = q_idx.pop_front();
        lat = q_cyc.pop_front();
        bad = drive_bad[idx];
        if (wb_data !== t_data[idx]) begin
          $display("mismatch %0t wb_data exp %h got %h", $time, t_data[idx], wb_data);
          bad = 1'b1;
        end
        if (wb_pc !== t_pc[idx]) begin
          $display("mismatch %0t wb_pc exp %h got %h", $time, t_pc[idx], wb_pc);
          bad = 1'b1;
        end
        if (wb_rd_ena !== (t_st[idx] == rv_pkg::ST_NONE)) begin
          $display("mismatch %0t wb_rd_ena exp %b got %b", $time,
                   t_st[idx] == rv_pkg::ST_NONE, wb_rd_ena);
          bad = 1'b1;
        end
        if (wb_rd_addr !== 5'(idx % 31 + 1)) begin
          $display("mismatch %0t wb_rd_addr exp %0d got %0d", $time, idx % 31 + 1, wb_rd_addr);
          bad = 1'b1;
        end
        if (check_lat && (cycle - lat != 2)) begin
          $display("%0t: test %0d did not write back 2 cycles after acceptance", $time, idx);
          bad = 1'b1;
        end
        if (bad) begin
          n_fail++;
          errors++;
          $display("test %0d failed", idx);
        end else begin
          n_pass++;
          $display("test %0d ok", idx);
        end
      end
    end
  end

  task automatic run_table;
    for (int i = 0; i < NT; i++) begin
      @(negedge clk);
      id_ex_valid = 1'b1;
      pc_in = t_pc[i];
      op1_src = t_op1[i];
      op2_src = t_op2[i];
      alu_op = t_alu[i];
      is_word_opt = t_word[i];
      bj_op = t_bj[i];
      jmp_imm = t_imm[i];
      load_op_in = t_ld[i];
      save_op_in = t_st[i];
      mem_wr_src_in = t_wsrc[i];
      rd_ena_in = (t_st[i] == rv_pkg::ST_NONE);
      rd_addr_in = 5'(i % 31 + 1);
      drive_bad[i] = 1'b0;
      #1;
      if (bj_ena !== t_bjena[i]) begin
        $display("mismatch %0t bj_ena exp %b got %b", $time, t_bjena[i], bj_ena);
        drive_bad[i] = 1'b1;
      end
      if (new_pc !== t_npc[i]) begin
        $display("mismatch %0t new_pc exp %h got %h", $time, t_npc[i], new_pc);
        drive_bad[i] = 1'b1;
      end
      // hold until ex takes it
      do @(posedge clk); while (!ex_allowin);
      q_idx.push_back(i);
      q_cyc.push_back(cycle);
    end
    @(negedge clk);
    id_ex_valid = 1'b0;
    while (q_idx.size() != 0) begin
      @(posedge clk);
    end
  endtask

  initial begin
    rst = 1'b1;
    id_ex_valid = 1'b0;
    pc_in = '0;
    op1_src = '0;
    op2_src = '0;
    alu_op = rv_pkg::ALU_ADD;
    is_word_opt = 1'b0;
    // a jump with no valid instruction must not redirect
    bj_op = rv_pkg::BJ_JAL;
    jmp_imm = '0;
    load_op_in = rv_pkg::LD_NONE;
    save_op_in = rv_pkg::ST_NONE;
    mem_wr_src_in = '0;
    rd_ena_in = 1'b0;
    rd_addr_in = '0;
    wb_allowin = 1'b1;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    if (mem_wb_valid !== 1'b0 || ex_allowin !== 1'b1 || bj_ena !== 1'b0) begin
      $display("%0t: pipe not empty and ready after reset", $time);
      errors++;
    end
    // stall free pass, then random back-pressure
    run_table();
    bp_on = 1'b1;
    @(negedge clk);
    check_lat = 1'b0;
    run_table();
    repeat (3) @(posedge clk);
    $display("passed %0d failed %0d errors %0d", n_pass, n_fail, errors);
    if (errors == 0 && n_pass == RUNS * NT) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rv_pkg.sv
ex_stage_alu.sv
ex_stage_bj.sv
ex_stage.sv
mem_stage.sv
exec_pipe_top.sv
exec_pipe_asserts.sv
tb_exec_pipe.sv

// File: run.sh
#!/bin/sh
# build and run the execute pipe testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exec_pipe -f all.f -o sim_exec_pipe \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_exec_pipe > sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
